// ==== rvIsaPkg.sv ====
package rvIsaPkg;

    // Data path and register index widths
    localparam int xlen = 32;
    localparam int regAddrWidth = 5;

    // Instruction field widths
    localparam int opcodeWidth = 7;
    localparam int funct3Width = 3;
    localparam int funct7Width = 7;
    localparam int shamtWidth = 5;

    // Opcodes handled by this slice, anything else is illegal
    typedef enum logic [opcodeWidth-1:0] {
        opLui   = 7'b0110111,
        opAuipc = 7'b0010111,
        opImm   = 7'b0010011,
        opReg   = 7'b0110011
    } opcodeE;

    // funct3 codes shared by the OP and OP-IMM groups
    localparam logic [funct3Width-1:0] f3AddSub = 3'b000;
    localparam logic [funct3Width-1:0] f3Sll    = 3'b001;
    localparam logic [funct3Width-1:0] f3Slt    = 3'b010;
    localparam logic [funct3Width-1:0] f3Sltu   = 3'b011;
    localparam logic [funct3Width-1:0] f3Xor    = 3'b100;
    localparam logic [funct3Width-1:0] f3Srl    = 3'b101;
    localparam logic [funct3Width-1:0] f3Or     = 3'b110;
    localparam logic [funct3Width-1:0] f3And    = 3'b111;

    // funct7 codes, bit 5 selects SUB and SRA
    localparam logic [funct7Width-1:0] f7Base = 7'b0000000;
    localparam logic [funct7Width-1:0] f7Alt  = 7'b0100000;

endpackage

// ==== rvPipePkg.sv ====
package rvPipePkg;

    import rvIsaPkg::*;

    // Machine word and register index
    typedef logic [xlen-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regIdxT;

    // Bits of operand B used as the shift distance
    localparam int shiftWidth = $clog2(xlen);

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9
    } aluOpE;

    // Item as issued, operands already read from the register bank
    typedef struct packed {
        wordT instr;
        wordT pc;
        wordT rs1Value;
        wordT rs2Value;
    } issueT;

    // Decode to execute
    typedef struct packed {
        aluOpE  aluOp;
        wordT   operandA;
        wordT   operandB;
        regIdxT rd;
        logic   regWrite;
        logic   illegal;
    } decodedT;

    // Register write record
    typedef struct packed {
        regIdxT rd;
        wordT   value;
        logic   writeEnable;
        logic   illegal;
    } resultT;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
    import rvIsaPkg::*;
    import rvPipePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  issueT   inItem,
    output logic    decValid,
    input  logic    decReady,
    output decodedT decItem
);

    opcodeE                 opcode;
    logic [funct3Width-1:0] funct3;
    logic [funct7Width-1:0] funct7;
    logic [shamtWidth-1:0]  shamt;
    regIdxT                 rd;
    wordT                   immI;
    wordT                   immU;
    wordT                   shamtExt;
    logic                   isShift;
    logic                   funct7Checked;
    logic                   funct7Ok;
    logic                   useAlt;
    aluOpE                  aluSel;
    decodedT                nextItem;
    logic                   accept;

    // Field extraction
    assign opcode = opcodeE'(inItem.instr[opcodeWidth-1:0]);
    assign rd     = inItem.instr[11:7];
    assign funct3 = inItem.instr[14:12];
    assign shamt  = inItem.instr[24:20];
    assign funct7 = inItem.instr[31:25];

    // I immediate is sign-extended, U immediate fills the upper 20 bits
    assign immI     = {{(xlen-12){inItem.instr[31]}}, inItem.instr[31:20]};
    assign immU     = {inItem.instr[31:12], 12'b0};
    assign shamtExt = {{(xlen-shamtWidth){1'b0}}, shamt};

    assign isShift = (funct3 == f3Sll) || (funct3 == f3Srl);

    // funct7 only matters on shifts and on R-type ADD/SUB
    always_comb
    begin
        funct7Checked = isShift || (opcode == opReg && funct3 == f3AddSub);
        useAlt        = funct7Checked && (funct7 == f7Alt) && (funct3 != f3Sll);
        funct7Ok      = !funct7Checked || (funct7 == f7Base) || useAlt;
    end

    always_comb
    begin
        case (funct3)
            f3AddSub: aluSel = useAlt ? aluSub : aluAdd;
            f3Sll:    aluSel = aluSll;
            f3Slt:    aluSel = aluSlt;
            f3Sltu:   aluSel = aluSltu;
            f3Xor:    aluSel = aluXor;
            f3Srl:    aluSel = useAlt ? aluSra : aluSrl;
            f3Or:     aluSel = aluOr;
            default:  aluSel = aluAnd;
        endcase
    end

    // Operand selection per format
    always_comb
    begin
        nextItem          = '0;
        nextItem.aluOp    = aluAdd;
        nextItem.rd       = rd;
        nextItem.regWrite = 1'b1;
        case (opcode)
            opLui:
            begin
                nextItem.operandB = immU;
            end
            opAuipc:
            begin
                nextItem.operandA = inItem.pc;
                nextItem.operandB = immU;
            end
            opImm:
            begin
                nextItem.aluOp    = aluSel;
                nextItem.operandA = inItem.rs1Value;
                nextItem.operandB = isShift ? shamtExt : immI;
                nextItem.illegal  = !funct7Ok;
            end
            opReg:
            begin
                nextItem.aluOp    = aluSel;
                nextItem.operandA = inItem.rs1Value;
                nextItem.operandB = inItem.rs2Value;
                nextItem.illegal  = !funct7Ok;
            end
            default:
            begin
                nextItem.illegal = 1'b1;
            end
        endcase

        // Illegal items become a no-write ADD of zeros
        if (nextItem.illegal)
        begin
            nextItem.aluOp    = aluAdd;
            nextItem.operandA = '0;
            nextItem.operandB = '0;
            nextItem.regWrite = 1'b0;
        end
    end

    // Output register handshake
    assign inReady = !decValid || decReady;
    assign accept  = inValid && inReady;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            decValid <= 1'b0;
        end
        else if (inReady)
        begin
            decValid <= inValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            decItem <= nextItem;
        end
    end

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

module aluExecute
    import rvPipePkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    decValid,
    output logic    decReady,
    input  decodedT decItem,
    output logic    exValid,
    input  logic    exReady,
    output resultT  exItem
);

    wordT                  opA;
    wordT                  opB;
    logic [shiftWidth-1:0] shiftAmt;
    wordT                  aluValue;
    resultT                nextItem;
    logic                  accept;

    assign opA      = decItem.operandA;
    assign opB      = decItem.operandB;
    assign shiftAmt = opB[shiftWidth-1:0];

    always_comb
    begin
        case (decItem.aluOp)
            aluAdd:  aluValue = opA + opB;
            aluSub:  aluValue = opA - opB;
            aluAnd:  aluValue = opA & opB;
            aluOr:   aluValue = opA | opB;
            aluXor:  aluValue = opA ^ opB;
            aluSll:  aluValue = opA << shiftAmt;
            aluSrl:  aluValue = opA >> shiftAmt;
            // Arithmetic shift keeps the sign of operand A
            aluSra:  aluValue = $signed(opA) >>> shiftAmt;
            aluSlt:  aluValue = wordT'($signed(opA) < $signed(opB));
            aluSltu: aluValue = wordT'(opA < opB);
            default: aluValue = '0;
        endcase
    end

    always_comb
    begin
        nextItem.rd          = decItem.rd;
        nextItem.value       = aluValue;
        nextItem.writeEnable = decItem.regWrite;
        nextItem.illegal     = decItem.illegal;
    end

    // One register slot between decode and result
    assign decReady = !exValid || exReady;
    assign accept   = decValid && decReady;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exValid <= 1'b0;
        end
        else if (decReady)
        begin
            exValid <= decValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            exItem <= nextItem;
        end
    end

endmodule

// ==== resultStage.sv ====
`timescale 1ns/1ps

module resultStage
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   exValid,
    output logic   exReady,
    input  resultT exItem,
    output logic   outValid,
    input  logic   outReady,
    output resultT outItem
);

    resultT nextItem;
    logic   accept;

    // x0 is hardwired to zero, so never request a write to it
    always_comb
    begin
        nextItem             = exItem;
        nextItem.writeEnable = exItem.writeEnable && (exItem.rd != '0);
    end

    // Record waits here while the consumer stalls
    assign exReady = !outValid || outReady;
    assign accept  = exValid && exReady;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
        end
        else if (exReady)
        begin
            outValid <= exValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            outItem <= nextItem;
        end
    end

endmodule

// ==== intCoreSlice.sv ====
`timescale 1ns/1ps

module intCoreSlice
    import rvPipePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   inValid,
    output logic   inReady,
    input  issueT  inItem,
    output logic   outValid,
    input  logic   outReady,
    output resultT outItem
);

    // Decode to execute link
    logic    decValid;
    logic    decReady;
    decodedT decItem;

    // Execute to result link
    logic   exValid;
    logic   exReady;
    resultT exItem;

    instrDecoder u_decode (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inItem   (inItem),
        .decValid (decValid),
        .decReady (decReady),
        .decItem  (decItem)
    );

    aluExecute u_execute (
        .clk      (clk),
        .rst      (rst),
        .decValid (decValid),
        .decReady (decReady),
        .decItem  (decItem),
        .exValid  (exValid),
        .exReady  (exReady),
        .exItem   (exItem)
    );

    resultStage u_result (
        .clk      (clk),
        .rst      (rst),
        .exValid  (exValid),
        .exReady  (exReady),
        .exItem   (exItem),
        .outValid (outValid),
        .outReady (outReady),
        .outItem  (outItem)
    );

endmodule

// ==== intCoreSlice_props.sv ====
`timescale 1ns/1ps

module intCoreSlice_props
    import rvPipePkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   inValid,
    input logic   inReady,
    input issueT  inItem,
    input logic   outValid,
    input logic   outReady,
    input resultT outItem
);

    // Producer keeps the item steady until it is taken
    inputHeld: assert property (@(posedge clk) disable iff (rst)
        inValid && !inReady |=> inValid && $stable(inItem))
        else $error("inValid dropped or inItem changed before acceptance");

    outputHeld: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outItem))
        else $error("outValid dropped or outItem changed under back-pressure");

    // Pipeline is empty in and right after reset
    resetEmpty: assert property (@(posedge clk) rst |-> !outValid)
        else $error("outValid high during reset");

    afterReset: assert property (@(posedge clk) $fell(rst) |-> !outValid)
        else $error("outValid high right after reset");

    noZeroWrite: assert property (@(posedge clk) disable iff (rst)
        outValid |-> !(outItem.writeEnable && outItem.rd == '0))
        else $error("writeEnable set for register zero");

endmodule

bind intCoreSlice intCoreSlice_props u_props (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inItem   (inItem),
    .outValid (outValid),
    .outReady (outReady),
    .outItem  (outItem)
);

// ==== tbIntCoreSlice.sv ====
`timescale 1ns/1ps

module tbIntCoreSlice
    import rvIsaPkg::*;
    import rvPipePkg::*;
;

    localparam logic [31:0] seed = 32'h9215_1514;
    localparam int numStim = 30;
    localparam int readyLimit = 200;
    localparam int drainLimit = 500;

    // Table row with random operands unless fixed is set
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        regIdxT     rd;
        wordT       imm;
        logic       fixed;
        wordT       fixA;
        wordT       fixB;
    } stimT;

    logic   clk;
    logic   rst;
    logic   inValid;
    logic   inReady;
    issueT  inItem;
    logic   outValid;
    logic   outReady;
    resultT outItem;

    stimT   stimTable [numStim];
    resultT expQ [$];
    logic [31:0] randState;
    logic [31:0] stallState;
    logic   stallMode;

    intCoreSlice i_dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inItem   (inItem),
        .outValid (outValid),
        .outReady (outReady),
        .outItem  (outItem)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic stimT makeStim(input logic [6:0] opcode, input logic [2:0] funct3,
                                      input logic [6:0] funct7, input regIdxT rd,
                                      input wordT imm, input logic fixed,
                                      input wordT fixA, input wordT fixB);
        stimT s;
        s.opcode = opcode;
        s.funct3 = funct3;
        s.funct7 = funct7;
        s.rd     = rd;
        s.imm    = imm;
        s.fixed  = fixed;
        s.fixA   = fixA;
        s.fixB   = fixB;
        return s;
    endfunction

    // Register indices x6 for rs1 and x7 for rs2 since values come with the item
    function automatic wordT encodeInstr(input stimT s);
        logic isShift;
        isShift = (s.funct3 == f3Sll) || (s.funct3 == f3Srl);
        if (s.opcode == opLui || s.opcode == opAuipc)
            return {s.imm[31:12], s.rd, s.opcode};
        else if (s.opcode == opImm && isShift)
            return {s.funct7, s.imm[4:0], 5'd6, s.funct3, s.rd, s.opcode};
        else if (s.opcode == opImm)
            return {s.imm[11:0], 5'd6, s.funct3, s.rd, s.opcode};
        else
            return {s.funct7, 5'd7, 5'd6, s.funct3, s.rd, s.opcode};
    endfunction

    // Reference model from the RV32I rules
    function automatic resultT expectFor(input stimT s, input issueT item);
        resultT r;
        logic   legal;
        wordT   a;
        wordT   b;
        wordT   v;
        logic [4:0] sh;
        legal = 1'b1;
        v     = '0;
        a     = item.rs1Value;
        b     = (s.opcode == opImm) ? {{20{s.imm[11]}}, s.imm[11:0]} : item.rs2Value;
        sh    = (s.opcode == opImm) ? s.imm[4:0] : item.rs2Value[4:0];
        if (s.opcode == opLui)
            v = {s.imm[31:12], 12'b0};
        else if (s.opcode == opAuipc)
            v = item.pc + {s.imm[31:12], 12'b0};
        else if (s.opcode == opImm || s.opcode == opReg)
        begin
            case (s.funct3)
                f3AddSub:
                begin
                    if (s.opcode == opReg && s.funct7 == f7Alt)
                        v = a - b;
                    else if (s.opcode == opImm || s.funct7 == f7Base)
                        v = a + b;
                    else
                        legal = 1'b0;
                end
                f3Sll:
                begin
                    if (s.funct7 == f7Base)
                        v = a << sh;
                    else
                        legal = 1'b0;
                end
                f3Slt:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                f3Sltu: v = (a < b) ? 32'd1 : 32'd0;
                f3Xor:  v = a ^ b;
                f3Or:   v = a | b;
                f3And:  v = a & b;
                default:
                begin
                    if (s.funct7 == f7Base)
                        v = a >> sh;
                    else if (s.funct7 == f7Alt)
                        v = $signed(a) >>> sh;
                    else
                        legal = 1'b0;
                end
            endcase
        end
        else
            legal = 1'b0;
        r.rd          = s.rd;
        r.value       = legal ? v : '0;
        r.writeEnable = legal && (s.rd != 5'd0);
        r.illegal     = !legal;
        return r;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
            failRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
    endtask

    // Called on a falling edge and returns on the next falling edge
    task automatic sendItem(input stimT s);
        issueT item;
        int    waitCycles;
        logic  accepted;
        randState     = xorshift32(randState);
        item.pc       = randState & 32'hffff_fffc;
        randState     = xorshift32(randState);
        item.rs1Value = s.fixed ? s.fixA : randState;
        randState     = xorshift32(randState);
        item.rs2Value = s.fixed ? s.fixB : randState;
        item.instr    = encodeInstr(s);
        inItem   = item;
        inValid  = 1'b1;
        accepted = 1'b0;
        waitCycles = 0;
        while (!accepted)
        begin
            @(posedge clk);
            if (inReady)
                accepted = 1'b1;
            else
            begin
                waitCycles++;
                if (waitCycles > readyLimit)
                    failRun("Timed out waiting for inReady");
            end
        end
        expQ.push_back(expectFor(s, item));
        @(negedge clk);
        inValid = 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Consumer side back-pressure
    initial
    begin
        outReady   = 1'b1;
        stallState = seed;
        forever
        begin
            @(negedge clk);
            if (stallMode)
            begin
                stallState = xorshift32(stallState);
                outReady   = (stallState[1:0] != 2'b00);
            end
            else
                outReady = 1'b1;
        end
    end

    // Output monitor
    initial
    begin
        resultT exp;
        forever
        begin
            @(posedge clk);
            if (!rst && outValid && outReady)
            begin
                if (expQ.size() == 0)
                    failRun("An output arrived that no input accounts for");
                else
                begin
                    exp = expQ.pop_front();
                    checkValue("outItem.value", outItem.value, exp.value);
                    checkValue("outItem.rd", 32'(outItem.rd), 32'(exp.rd));
                    checkValue("outItem.writeEnable", 32'(outItem.writeEnable),
                               32'(exp.writeEnable));
                    checkValue("outItem.illegal", 32'(outItem.illegal), 32'(exp.illegal));
                end
            end
        end
    end

    initial
    begin
        int waitCycles;
        rst       = 1'b1;
        inValid   = 1'b0;
        inItem    = '0;
        stallMode = 1'b0;
        randState = seed;

        // Fixed R-type operands cover SUB wraparound and signed compare
        stimTable[0]  = makeStim(opReg, f3AddSub, f7Base, 5'd1, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[1]  = makeStim(opReg, f3AddSub, f7Alt, 5'd2, 32'h0, 1'b1, 32'h1, 32'h2);
        stimTable[2]  = makeStim(opReg, f3AddSub, f7Alt, 5'd3, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[3]  = makeStim(opReg, f3And, f7Base, 5'd4, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[4]  = makeStim(opReg, f3Or, f7Base, 5'd5, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[5]  = makeStim(opReg, f3Xor, f7Base, 5'd6, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[6]  = makeStim(opReg, f3Sll, f7Base, 5'd7, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[7]  = makeStim(opReg, f3Srl, f7Base, 5'd8, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[8]  = makeStim(opReg, f3Srl, f7Alt, 5'd9, 32'h0, 1'b1, 32'h8000_0010, 32'h4);
        stimTable[9]  = makeStim(opReg, f3Slt, f7Base, 5'd10, 32'h0, 1'b1, 32'hffff_ffff, 32'h1);
        stimTable[10] = makeStim(opReg, f3Sltu, f7Base, 5'd11, 32'h0, 1'b1, 32'hffff_ffff, 32'h1);
        stimTable[11] = makeStim(opReg, f3Slt, f7Base, 5'd12, 32'h0, 1'b0, 32'h0, 32'h0);
        // I-type with negative immediates
        stimTable[12] = makeStim(opImm, f3AddSub, f7Base, 5'd13, 32'hffb, 1'b0, 32'h0, 32'h0);
        stimTable[13] = makeStim(opImm, f3Slt, f7Base, 5'd14, 32'h800, 1'b1, 32'h0, 32'h0);
        stimTable[14] = makeStim(opImm, f3Sltu, f7Base, 5'd15, 32'hfff, 1'b1, 32'h5, 32'h0);
        stimTable[15] = makeStim(opImm, f3Xor, f7Base, 5'd16, 32'hfff, 1'b0, 32'h0, 32'h0);
        stimTable[16] = makeStim(opImm, f3Or, f7Base, 5'd17, 32'h0f0, 1'b0, 32'h0, 32'h0);
        stimTable[17] = makeStim(opImm, f3And, f7Base, 5'd18, 32'h8f0, 1'b0, 32'h0, 32'h0);
        stimTable[18] = makeStim(opImm, f3Sll, f7Base, 5'd19, 32'h1f, 1'b0, 32'h0, 32'h0);
        stimTable[19] = makeStim(opImm, f3Srl, f7Base, 5'd20, 32'h4, 1'b1, 32'h8000_0000, 32'h0);
        stimTable[20] = makeStim(opImm, f3Srl, f7Alt, 5'd21, 32'h4, 1'b1, 32'h8000_0000, 32'h0);
        // Upper immediates
        stimTable[21] = makeStim(opLui, 3'b0, f7Base, 5'd22, 32'habcd_e000, 1'b0, 32'h0, 32'h0);
        stimTable[22] = makeStim(opAuipc, 3'b0, f7Base, 5'd23, 32'h1234_5000, 1'b0, 32'h0, 32'h0);
        // Writes to x0
        stimTable[23] = makeStim(opReg, f3AddSub, f7Base, 5'd0, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[24] = makeStim(opImm, f3AddSub, f7Base, 5'd0, 32'h123, 1'b0, 32'h0, 32'h0);
        stimTable[25] = makeStim(opLui, 3'b0, f7Base, 5'd0, 32'h0000_1000, 1'b0, 32'h0, 32'h0);
        // Unsupported opcode and bad funct7
        stimTable[26] = makeStim(7'b0000011, 3'b010, f7Base, 5'd24, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[27] = makeStim(opReg, f3AddSub, 7'h01, 5'd25, 32'h0, 1'b0, 32'h0, 32'h0);
        stimTable[28] = makeStim(opImm, f3Sll, f7Alt, 5'd26, 32'h3, 1'b0, 32'h0, 32'h0);
        stimTable[29] = makeStim(opReg, f3Srl, 7'h7f, 5'd27, 32'h0, 1'b0, 32'h0, 32'h0);

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Streaming pass and then a pass with consumer stalls
        for (int i = 0; i < numStim; i++)
            sendItem(stimTable[i]);
        stallMode = 1'b1;
        for (int i = 0; i < numStim; i++)
            sendItem(stimTable[i]);

        waitCycles = 0;
        while (expQ.size() != 0)
        begin
            @(posedge clk);
            waitCycles++;
            if (waitCycles > drainLimit)
                failRun("Timed out waiting for the pipeline to drain");
        end
        stallMode = 1'b0;

        // Any extra result in these cycles trips the monitor
        repeat (5) @(posedge clk);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== verilog.f ====
rvIsaPkg.sv
rvPipePkg.sv
instrDecoder.sv
aluExecute.sv
resultStage.sv
intCoreSlice.sv
intCoreSlice_props.sv
tbIntCoreSlice.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tbIntCoreSlice -f verilog.f -o simIntCoreSlice || exit 1

simOut=$(./obj_dir/simIntCoreSlice)
echo "$simOut"
echo "$simOut" | grep -qx "All tests passed!" && echo "Simulation PASSED" && exit 0 || \
    { echo "Simulation FAILED"; exit 1; }
